// ==== Bender.yml ====
package:
  name: alu_ldpc

sources:
  - common/alu_pkg.sv
  - ldpc/ldpc_lane.sv
  - ldpc/ldpc_simd_unit.sv
  - logic/alu_issue_stage.sv
  - logic/alu_int_unit.sv
  - logic/alu_result_stage.sv
  - logic/alu_top.sv
  - target: test
    include_dirs:
      - bench
    files:
      - bench/tb_clock_gen.sv
      - bench/alu_tb.sv

// ==== bench/alu_model.svh ====
// ALU reference model
`ifndef ALU_MODEL_SVH
`define ALU_MODEL_SVH

// --------------------------------------------------
// Reference functions
// --------------------------------------------------
function automatic bit is_ldpc_op(alu_op_e op);
    return op inside {LDPC_ADD_SAT, LDPC_SUB_SAT, LDPC_SIGN, LDPC_MIN, LDPC_MAX,
                      LDPC_ABS, LDPC_NMESS, LDPC_EVAL, LDPC_RSIGN};
endfunction

// Symmetric clamp of the true sum
function automatic llr_t clamp_llr(int v);
    if (v > LLR_SAT) begin
        return llr_t'(LLR_SAT);
    end
    if (v < -LLR_SAT) begin
        return llr_t'(-LLR_SAT);
    end
    return llr_t'(v);
endfunction

function automatic llr_t model_lane(alu_op_e op, llr_t a, llr_t b);
    case (op)
        LDPC_ADD_SAT: return clamp_llr(int'(a) + int'(b));
        LDPC_SUB_SAT: return clamp_llr(int'(a) - int'(b));
        LDPC_SIGN:    return (a < 0) ? llr_t'(1) : llr_t'(0);
        LDPC_MIN:     return (a >= b) ? b : a;
        LDPC_MAX:     return (a >= b) ? a : b;
        LDPC_ABS:     return (a < 0) ? llr_t'(-int'(a)) : a;
        LDPC_NMESS:   return (a != 0) ? b : llr_t'(-int'(b));
        LDPC_EVAL:    return (a == b) ? llr_t'(8'hff) : llr_t'(8'h00);
        LDPC_RSIGN:   return (b >= 0) ? (a ^ llr_t'(1)) : a;
        default:      return llr_t'(0);
    endcase
endfunction

function automatic alu_rsp_t model_int(alu_op_e op, xlen_t a, xlen_t b);
    alu_rsp_t    rsp;
    int unsigned sh;
    sh               = b[SHAMT_W-1:0];
    rsp.result       = '0;
    rsp.branch_taken = 1'b1;
    case (op)
        ADD:  rsp.result = a + b;
        SUB:  rsp.result = a - b;
        ANDL: rsp.result = a & b;
        ORL:  rsp.result = a | b;
        XORL: rsp.result = a ^ b;
        ANDN: rsp.result = a & ~b;
        ORN:  rsp.result = a | ~b;
        XNOR: rsp.result = a ^ ~b;
        SLL:  rsp.result = a << sh;
        SRL:  rsp.result = a >> sh;
        SRA:  rsp.result = xlen_t'($signed(a) >>> sh);
        SLTS: rsp.result[0] = ($signed(a) < $signed(b));
        SLTU: rsp.result[0] = (a < b);
        EQ:   rsp.branch_taken = (a == b);
        NE:   rsp.branch_taken = (a != b);
        LTS:  rsp.branch_taken = ($signed(a) < $signed(b));
        LTU:  rsp.branch_taken = (a < b);
        GES:  rsp.branch_taken = ($signed(a) >= $signed(b));
        GEU:  rsp.branch_taken = (a >= b);
        default: ;
    endcase
    return rsp;
endfunction

function automatic alu_rsp_t model_alu(alu_req_t r);
    alu_rsp_t rsp;
    if (is_ldpc_op(r.op)) begin
        rsp.branch_taken = 1'b1;
        // Byte i of each word is lane i
        for (int i = 0; i < LANES; i++) begin
            rsp.result[LLR_W*i +: LLR_W] = model_lane(r.op,
                llr_t'(r.operand_a.word[LLR_W*i +: LLR_W]),
                llr_t'(r.operand_b.word[LLR_W*i +: LLR_W]));
        end
    end else begin
        rsp = model_int(r.op, r.operand_a.word, r.operand_b.word);
    end
    return rsp;
endfunction

// --------------------------------------------------
// Compare tasks
// --------------------------------------------------
task automatic check_result(input string name, input xlen_t exp, input xlen_t act);
    if (act !== exp) begin
        report_and_stop($sformatf("[FAIL] %s result: expected %h, actual %h", name, exp, act));
    end
endtask

task automatic check_branch(input string name, input logic exp, input logic act);
    if (act !== exp) begin
        report_and_stop($sformatf("[FAIL] %s branch: expected %b, actual %b", name, exp, act));
    end
endtask

`endif

// ==== bench/alu_tb.sv ====
// ALU testbench
`default_nettype none

module alu_tb;
    import alu_pkg::*;

    localparam int DRIVE_DLY   = 10;
    localparam int RESET_CYC   = 10;
    localparam int STALL_LIMIT = 100;
    localparam int DRAIN_LIMIT = 20;

    logic     clk;
    logic     reset;
    logic     req_valid;
    logic     req_ready;
    alu_req_t req;
    logic     rsp_valid;
    logic     rsp_ready;
    alu_rsp_t rsp;

    integer   seed;
    int       sample_idx;
    int       stall_cycles;
    int       req_count;
    int       rsp_count;

    // Expected responses in acceptance order
    alu_rsp_t exp_q[$];
    string    name_q[$];
    int       acc_q[$];

    tb_clock_gen u_clk (
        .clk_o (clk)
    );

    alu_top uut (
        .clk_i       (clk),
        .reset_i     (reset),
        .req_valid_i (req_valid),
        .req_ready_o (req_ready),
        .req_i       (req),
        .rsp_valid_o (rsp_valid),
        .rsp_ready_i (rsp_ready),
        .rsp_o       (rsp)
    );

    task automatic report_and_stop(input string msg);
        $display("%s", msg);
        $display("Errors found");
        $fatal(1, "Simulation stopped at the first error");
    endtask

    `include "alu_model.svh"

    // --------------------------------------------------
    // Stimulus
    // --------------------------------------------------
    function automatic xlen_t rand_word();
        xlen_t w;
        w = {$random(seed), $random(seed)};
        // Boundary lanes for the saturation corners
        if ($unsigned($random(seed)) % 4 == 0) begin
            for (int i = 0; i < LANES; i++) begin
                case ($unsigned($random(seed)) % 6)
                    0: w[LLR_W*i +: LLR_W] = 8'h7f;
                    1: w[LLR_W*i +: LLR_W] = 8'h81;
                    2: w[LLR_W*i +: LLR_W] = 8'h80;
                    3: w[LLR_W*i +: LLR_W] = 8'h00;
                    default: ;
                endcase
            end
        end
        return w;
    endfunction

    task automatic make_request();
        int idx;
        idx    = $unsigned($random(seed)) % 28;
        req.op = (idx < 19) ? alu_op_e'(idx) : alu_op_e'(idx + 13);
        req.operand_a.word = rand_word();
        if ($unsigned($random(seed)) % 8 == 0) begin
            req.operand_b.word = req.operand_a.word;
        end else begin
            req.operand_b.word = rand_word();
        end
    endtask

    // One clock cycle: sample at the falling edge, drive after the rising edge
    task automatic step_cycle(input bit gen_new, input int ready_pct, input bit check_lat);
        bit       req_fire;
        bit       rsp_fire;
        logic     exp_ready;
        alu_rsp_t exp_rsp;
        string    name;
        int       acc_idx;
        @(negedge clk);
        sample_idx++;
        req_fire  = req_valid && req_ready;
        rsp_fire  = rsp_valid && rsp_ready;
        exp_ready = !(exp_q.size() == 2 && !rsp_ready);
        if (req_ready !== exp_ready) begin
            report_and_stop($sformatf("req_ready_o was %b with %0d requests in flight",
                                      req_ready, exp_q.size()));
        end
        if (rsp_fire) begin
            if (exp_q.size() == 0) begin
                report_and_stop("A response arrived with no request outstanding");
            end else begin
                exp_rsp = exp_q.pop_front();
                name    = name_q.pop_front();
                acc_idx = acc_q.pop_front();
                rsp_count++;
                check_result(name, exp_rsp.result, rsp.result);
                check_branch(name, exp_rsp.branch_taken, rsp.branch_taken);
                if (check_lat && (sample_idx - acc_idx != 2)) begin
                    report_and_stop($sformatf("%s came %0d cycles after acceptance, not 2",
                                              name, sample_idx - acc_idx));
                end
            end
        end
        if (req_fire) begin
            exp_q.push_back(model_alu(req));
            name_q.push_back($sformatf("%s #%0d", req.op.name(), req_count));
            acc_q.push_back(sample_idx);
            req_count++;
        end
        if (req_valid && !req_fire) begin
            stall_cycles++;
        end else begin
            stall_cycles = 0;
        end
        if (stall_cycles > STALL_LIMIT) begin
            report_and_stop("A request was never accepted by the DUT");
        end
        @(posedge clk);
        #DRIVE_DLY;
        // A raised valid holds its request until the transfer
        if (req_fire || !req_valid) begin
            if (gen_new && ($unsigned($random(seed)) % 4 != 0)) begin
                make_request();
                req_valid = 1'b1;
            end else begin
                req_valid = 1'b0;
            end
        end
        rsp_ready = ($unsigned($random(seed)) % 100) < ready_pct;
    endtask

    task automatic run_phase(input int cycles, input int ready_pct, input bit check_lat);
        for (int c = 0; c < cycles; c++) begin
            step_cycle(1'b1, ready_pct, check_lat);
        end
    endtask

    task automatic drain();
        int waited;
        waited = 0;
        while (req_valid || exp_q.size() != 0) begin
            if (waited >= DRAIN_LIMIT) begin
                report_and_stop("Outstanding responses did not drain in time");
            end else begin
                step_cycle(1'b0, 100, 1'b0);
                waited++;
            end
        end
    endtask

    // --------------------------------------------------
    // Test sequence
    // --------------------------------------------------
    initial begin
        seed         = 32'h26f2;
        sample_idx   = 0;
        stall_cycles = 0;
        req_count    = 0;
        rsp_count    = 0;
        reset        = 1'b1;
        req_valid    = 1'b0;
        req          = '0;
        rsp_ready    = 1'b0;
        repeat (RESET_CYC) @(posedge clk);
        #DRIVE_DLY;
        reset     = 1'b0;
        rsp_ready = 1'b1;
        @(negedge clk);
        if (rsp_valid !== 1'b0 || req_ready !== 1'b1) begin
            report_and_stop("Pipeline is not idle and ready after reset");
        end
        // Mixed back-pressure, then a stretch with ready held high
        run_phase(400, 50, 1'b0);
        drain();
        run_phase(200, 100, 1'b1);
        drain();
        run_phase(400, 20, 1'b0);
        drain();
        $display("%0d requests accepted, %0d responses checked", req_count, rsp_count);
        // Result register empty once every request is answered
        @(negedge clk);
        if (rsp_valid !== 1'b0) begin
            report_and_stop("The DUT presented a response that no request asked for");
        end else begin
            $display("No errors");
            $finish;
        end
    end

endmodule

`default_nettype wire

// ==== bench/tb_clock_gen.sv ====
// Testbench clock source
`default_nettype none

module tb_clock_gen (
    output logic clk_o
);
    // Period of 100 time units
    localparam int HALF_PERIOD = 50;

    initial begin
        clk_o = 1'b0;
        forever #HALF_PERIOD clk_o = ~clk_o;
    end

endmodule

`default_nettype wire

// ==== common/alu_pkg.sv ====
// ALU shared definitions
`default_nettype none

package alu_pkg;

    // --------------------------------------------------
    // Widths and limits
    // --------------------------------------------------
    localparam int XLEN    = 64;
    localparam int LLR_W   = 8;
    localparam int LANES   = XLEN / LLR_W;
    localparam int SHAMT_W = 6;

    // Symmetric clamp, -127 to 127
    localparam int LLR_SAT = 127;

    typedef logic [XLEN-1:0]         xlen_t;
    typedef logic signed [LLR_W-1:0] llr_t;

    // --------------------------------------------------
    // Operation encoding
    // --------------------------------------------------
    typedef enum logic [5:0] {
        // Arithmetic and logic
        ADD          = 6'd0,
        SUB          = 6'd1,
        ANDL         = 6'd2,
        ORL          = 6'd3,
        XORL         = 6'd4,
        ANDN         = 6'd5,
        ORN          = 6'd6,
        XNOR         = 6'd7,
        // Shifts
        SLL          = 6'd8,
        SRL          = 6'd9,
        SRA          = 6'd10,
        // Set less than
        SLTS         = 6'd11,
        SLTU         = 6'd12,
        // Branch compares
        EQ           = 6'd13,
        NE           = 6'd14,
        LTS          = 6'd15,
        LTU          = 6'd16,
        GES          = 6'd17,
        GEU          = 6'd18,
        // LDPC lane operations
        LDPC_ADD_SAT = 6'd32,
        LDPC_SUB_SAT = 6'd33,
        LDPC_SIGN    = 6'd34,
        LDPC_MIN     = 6'd35,
        LDPC_MAX     = 6'd36,
        LDPC_ABS     = 6'd37,
        LDPC_NMESS   = 6'd38,
        LDPC_EVAL    = 6'd39,
        LDPC_RSIGN   = 6'd40
    } alu_op_e;

    // --------------------------------------------------
    // Request and response
    // --------------------------------------------------

    // Scalar view for the integer unit, lane view for LDPC, lane 0 in the low byte
    typedef union packed {
        xlen_t                  word;
        llr_t [LANES-1:0]       lanes;
    } operand_u;

    typedef struct packed {
        alu_op_e  op;
        operand_u operand_a;
        operand_u operand_b;
    } alu_req_t;

    typedef struct packed {
        xlen_t result;
        logic  branch_taken;
    } alu_rsp_t;

endpackage

`default_nettype wire

// ==== flist.f ====
+incdir+bench
common/alu_pkg.sv
ldpc/ldpc_lane.sv
ldpc/ldpc_simd_unit.sv
logic/alu_issue_stage.sv
logic/alu_int_unit.sv
logic/alu_result_stage.sv
logic/alu_top.sv
bench/tb_clock_gen.sv
bench/alu_tb.sv

// ==== ldpc/ldpc_lane.sv ====
// LDPC lane datapath
`default_nettype none

module ldpc_lane (
    input  alu_pkg::alu_op_e op_i,
    input  alu_pkg::llr_t    a_i,
    input  alu_pkg::llr_t    b_i,
    output alu_pkg::llr_t    res_o
);
    import alu_pkg::*;

    logic signed [LLR_W:0] sum_ext;
    logic signed [LLR_W:0] diff_ext;
    llr_t                  r_addsat;
    llr_t                  r_subsat;
    logic                  a_ge_b;

    // --------------------------------------------------
    // Saturating add and subtract
    // --------------------------------------------------

    // One extra bit so the true result never wraps
    assign sum_ext  = {a_i[LLR_W-1], a_i} + {b_i[LLR_W-1], b_i};
    assign diff_ext = {a_i[LLR_W-1], a_i} - {b_i[LLR_W-1], b_i};

    assign r_addsat = (sum_ext > LLR_SAT)  ? llr_t'(LLR_SAT)  :
                      (sum_ext < -LLR_SAT) ? llr_t'(-LLR_SAT) :
                      sum_ext[LLR_W-1:0];

    assign r_subsat = (diff_ext > LLR_SAT)  ? llr_t'(LLR_SAT)  :
                      (diff_ext < -LLR_SAT) ? llr_t'(-LLR_SAT) :
                      diff_ext[LLR_W-1:0];

    assign a_ge_b = (a_i >= b_i);

    // --------------------------------------------------
    // Operation select
    // --------------------------------------------------
    always_comb begin
        case (op_i)
            LDPC_ADD_SAT: res_o = r_addsat;
            LDPC_SUB_SAT: res_o = r_subsat;
            LDPC_SIGN:    res_o = (a_i < 0) ? llr_t'(1) : llr_t'(0);
            LDPC_MIN:     res_o = a_ge_b ? b_i : a_i;
            LDPC_MAX:     res_o = a_ge_b ? a_i : b_i;
            // -128 wraps back to itself
            LDPC_ABS:     res_o = (a_i >= 0) ? a_i : -a_i;
            LDPC_NMESS:   res_o = (a_i != 0) ? b_i : -b_i;
            LDPC_EVAL:    res_o = (a_i == b_i) ? llr_t'(-1) : llr_t'(0);
            LDPC_RSIGN:   res_o = a_i ^ ((b_i >= 0) ? llr_t'(1) : llr_t'(0));
            default:      res_o = '0;
        endcase
    end

endmodule

`default_nettype wire

// ==== ldpc/ldpc_simd_unit.sv ====
// LDPC SIMD unit
`default_nettype none

module ldpc_simd_unit (
    input  alu_pkg::alu_req_t req_i,
    output alu_pkg::xlen_t    result_o
);
    import alu_pkg::*;

    llr_t [LANES-1:0] lane_res;

    // --------------------------------------------------
    // Lane array
    // --------------------------------------------------

    // Each lane decodes the operation on its own
    for (genvar i = 0; i < LANES; i++) begin : gen_lane
        ldpc_lane u_lane (
            .op_i  (req_i.op),
            .a_i   (req_i.operand_a.lanes[i]),
            .b_i   (req_i.operand_b.lanes[i]),
            .res_o (lane_res[i])
        );
    end

    // Lane i lands in byte i
    assign result_o = xlen_t'(lane_res);

endmodule

`default_nettype wire

// ==== logic/alu_int_unit.sv ====
// Integer and branch unit
`default_nettype none

module alu_int_unit (
    input  alu_pkg::alu_req_t req_i,
    output alu_pkg::alu_rsp_t rsp_o
);
    import alu_pkg::*;

    xlen_t              op_a;
    xlen_t              op_b;
    logic               negate_b;
    logic [XLEN:0]      operand_b_neg;
    logic [XLEN:0]      adder_sum;
    xlen_t              adder_result;
    logic               adder_z_flag;
    logic               shift_left;
    logic               shift_arith;
    logic [SHAMT_W-1:0] shift_amt;
    xlen_t              op_a_rev;
    xlen_t              shift_op_a;
    logic [XLEN:0]      shift_right_result;
    xlen_t              shift_left_result;
    xlen_t              shift_result;
    logic               cmp_signed;
    logic               less;

    assign op_a = req_i.operand_a.word;
    assign op_b = req_i.operand_b.word;

    // --------------------------------------------------
    // Adder
    // --------------------------------------------------
    always_comb begin
        case (req_i.op)
            SUB, EQ, NE, ANDN, ORN, XNOR: negate_b = 1'b1;
            default:                      negate_b = 1'b0;
        endcase
    end

    // Carry-in rides in bit 0 of both operands
    assign operand_b_neg = {op_b, 1'b0} ^ {(XLEN+1){negate_b}};
    assign adder_sum     = {op_a, 1'b1} + operand_b_neg;
    assign adder_result  = adder_sum[XLEN:1];
    assign adder_z_flag  = ~|adder_result;

    // --------------------------------------------------
    // Shifter
    // --------------------------------------------------
    assign shift_left  = (req_i.op == SLL);
    assign shift_arith = (req_i.op == SRA);
    assign shift_amt   = op_b[SHAMT_W-1:0];

    // Left shift = reverse, shift right, reverse back
    always_comb begin
        for (int k = 0; k < XLEN; k++) begin
            op_a_rev[k]          = op_a[XLEN-1-k];
            shift_left_result[k] = shift_right_result[XLEN-1-k];
        end
    end

    assign shift_op_a         = shift_left ? op_a_rev : op_a;
    assign shift_right_result =
        $unsigned($signed({shift_arith & shift_op_a[XLEN-1], shift_op_a}) >>> shift_amt);
    assign shift_result = shift_left ? shift_left_result : shift_right_result[XLEN-1:0];

    // --------------------------------------------------
    // Comparator
    // --------------------------------------------------
    assign cmp_signed = (req_i.op == SLTS) || (req_i.op == LTS) || (req_i.op == GES);
    assign less = $signed({cmp_signed & op_a[XLEN-1], op_a}) <
                  $signed({cmp_signed & op_b[XLEN-1], op_b});

    // Result and branch outcome
    always_comb begin
        rsp_o.result       = '0;
        rsp_o.branch_taken = 1'b1;
        case (req_i.op)
            ADD, SUB:      rsp_o.result = adder_result;
            ANDL, ANDN:    rsp_o.result = op_a & operand_b_neg[XLEN:1];
            ORL, ORN:      rsp_o.result = op_a | operand_b_neg[XLEN:1];
            XORL, XNOR:    rsp_o.result = op_a ^ operand_b_neg[XLEN:1];
            SLL, SRL, SRA: rsp_o.result = shift_result;
            SLTS, SLTU:    rsp_o.result = {{(XLEN-1){1'b0}}, less};
            EQ:            rsp_o.branch_taken = adder_z_flag;
            NE:            rsp_o.branch_taken = ~adder_z_flag;
            LTS, LTU:      rsp_o.branch_taken = less;
            GES, GEU:      rsp_o.branch_taken = ~less;
            default: ;
        endcase
    end

endmodule

`default_nettype wire

// ==== logic/alu_issue_stage.sv ====
// ALU issue register
`default_nettype none

module alu_issue_stage (
    input  logic              clk_i,
    input  logic              reset_i,
    input  logic              req_valid_i,
    output logic              req_ready_o,
    input  alu_pkg::alu_req_t req_i,
    output logic              issue_valid_o,
    input  logic              issue_ready_i,
    output alu_pkg::alu_req_t issue_req_o
);
    import alu_pkg::*;

    logic     valid_q;
    alu_req_t req_q;

    // Free slot, or the held item leaves this cycle
    assign req_ready_o = ~valid_q | issue_ready_i;

    // Fill state
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            valid_q <= 1'b0;
        end else if (req_ready_o) begin
            valid_q <= req_valid_i;
        end
    end

    // Payload
    always_ff @(posedge clk_i) begin
        if (req_valid_i && req_ready_o) begin
            req_q <= req_i;
        end
    end

    assign issue_valid_o = valid_q;
    assign issue_req_o   = req_q;

endmodule

`default_nettype wire

// ==== logic/alu_result_stage.sv ====
// ALU result register
`default_nettype none

module alu_result_stage (
    input  logic              clk_i,
    input  logic              reset_i,
    input  logic              issue_valid_i,
    output logic              issue_ready_o,
    input  alu_pkg::alu_op_e  op_i,
    input  alu_pkg::alu_rsp_t int_rsp_i,
    input  alu_pkg::xlen_t    ldpc_result_i,
    output logic              rsp_valid_o,
    input  logic              rsp_ready_i,
    output alu_pkg::alu_rsp_t rsp_o
);
    import alu_pkg::*;

    alu_rsp_t rsp_d;
    alu_rsp_t rsp_q;
    logic     rsp_valid_q;

    // Unit select
    always_comb begin
        case (op_i)
            LDPC_ADD_SAT, LDPC_SUB_SAT, LDPC_SIGN,
            LDPC_MIN, LDPC_MAX, LDPC_ABS,
            LDPC_NMESS, LDPC_EVAL, LDPC_RSIGN: begin
                rsp_d.result       = ldpc_result_i;
                rsp_d.branch_taken = 1'b1;
            end
            default: rsp_d = int_rsp_i;
        endcase
    end

    assign issue_ready_o = ~rsp_valid_q | rsp_ready_i;

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            rsp_valid_q <= 1'b0;
        end else if (issue_ready_o) begin
            rsp_valid_q <= issue_valid_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (issue_valid_i && issue_ready_o) begin
            rsp_q <= rsp_d;
        end
    end

    assign rsp_valid_o = rsp_valid_q;
    assign rsp_o       = rsp_q;

endmodule

`default_nettype wire

// ==== logic/alu_top.sv ====
// ALU with LDPC extension
`default_nettype none

module alu_top (
    input  logic              clk_i,
    input  logic              reset_i,
    input  logic              req_valid_i,
    output logic              req_ready_o,
    input  alu_pkg::alu_req_t req_i,
    output logic              rsp_valid_o,
    input  logic              rsp_ready_i,
    output alu_pkg::alu_rsp_t rsp_o
);
    import alu_pkg::*;

    logic     issue_valid;
    logic     issue_ready;
    alu_req_t issue_req;
    alu_rsp_t int_rsp;
    xlen_t    ldpc_result;

    alu_issue_stage u_issue (
        .clk_i         (clk_i),
        .reset_i       (reset_i),
        .req_valid_i   (req_valid_i),
        .req_ready_o   (req_ready_o),
        .req_i         (req_i),
        .issue_valid_o (issue_valid),
        .issue_ready_i (issue_ready),
        .issue_req_o   (issue_req)
    );

    // Both units see the same registered request
    alu_int_unit u_int (
        .req_i (issue_req),
        .rsp_o (int_rsp)
    );

    ldpc_simd_unit u_ldpc (
        .req_i    (issue_req),
        .result_o (ldpc_result)
    );

    alu_result_stage u_result (
        .clk_i         (clk_i),
        .reset_i       (reset_i),
        .issue_valid_i (issue_valid),
        .issue_ready_o (issue_ready),
        .op_i          (issue_req.op),
        .int_rsp_i     (int_rsp),
        .ldpc_result_i (ldpc_result),
        .rsp_valid_o   (rsp_valid_o),
        .rsp_ready_i   (rsp_ready_i),
        .rsp_o         (rsp_o)
    );

endmodule

`default_nettype wire
